//--- test/game_input.txt
// Columns: act a1 a2 heard state index hit miss, all hex
// act 1 key, 2 tone (a1 half period, a2 periods), 3 silence (a1 cycles),
// 4 rest of 1200 cycles then tone, 0 end; state 0 idle 1 playing 2 win 3 fail
// Reset values
3 4 0 0 0 00 0 0
// Detector in idle: A, A x2, C x4, out of window, D, long silence
2 32 8 A 0 00 0 0
2 19 8 A 0 00 0 0
2 15 8 1 0 00 0 0
2 64 8 0 0 00 0 0
2 4B 8 3 0 00 0 0
3 4B0 0 0 0 00 0 0
// Start, first note right, second note wrong, back to idle
1 0 0 0 1 00 0 0
4 43 8 5 1 01 1 0
4 4B 8 3 3 01 0 1
1 0 0 3 0 00 0 0
// Abort during play
1 0 0 3 1 00 0 0
4 43 8 5 1 01 1 0
1 0 0 5 0 00 0 0
// Whole tune, two notes per line
1 0 0 5 1 00 0 0
4 43 8 5 1 01 1 0   4 38 8 8 1 02 1 0
4 4B 8 3 1 03 1 0   4 54 8 1 1 04 1 0
4 4B 8 3 1 05 1 0   4 43 8 5 1 06 1 0
4 38 8 8 1 07 1 0   4 4B 8 3 1 08 1 0
4 43 8 5 1 09 1 0   4 38 8 8 1 0A 1 0
4 4B 8 3 1 0B 1 0   4 54 8 1 1 0C 1 0
4 38 8 8 1 0D 1 0   4 3F 8 6 1 0E 1 0
4 43 8 5 1 0F 1 0   4 4B 8 3 1 10 1 0
4 43 8 5 1 11 1 0   4 38 8 8 1 12 1 0
4 4B 8 3 1 13 1 0   4 54 8 1 1 14 1 0
4 4B 8 3 1 15 1 0   4 43 8 5 1 16 1 0
4 38 8 8 1 17 1 0   4 4B 8 3 1 18 1 0
4 43 8 5 1 19 1 0   4 38 8 8 1 1A 1 0
4 4B 8 3 1 1B 1 0   4 54 8 1 1 1C 1 0
// Two G in a row, the rest between them makes the second one a new event
4 38 8 8 1 1D 1 0   4 38 8 8 1 1E 1 0
4 3F 8 6 1 1F 1 0   4 43 8 5 1 20 1 0
4 3F 8 6 1 21 1 0   4 43 8 5 1 22 1 0
4 54 8 1 1 23 1 0   4 3F 8 6 1 24 1 0
4 43 8 5 1 25 1 0   4 4B 8 3 1 26 1 0
4 43 8 5 1 27 1 0   4 4B 8 3 1 28 1 0
4 32 8 A 1 29 1 0   4 38 8 8 1 2A 1 0
4 3F 8 6 1 2B 1 0   4 43 8 5 1 2C 1 0
4 3F 8 6 1 2D 1 0   4 43 8 5 1 2E 1 0
4 54 8 1 1 2F 1 0   4 3F 8 6 1 30 1 0
4 54 8 1 1 31 1 0   4 43 8 5 1 32 1 0
4 38 8 8 1 33 1 0   4 4B 8 3 1 34 1 0
4 54 8 1 1 35 1 0   4 4B 8 3 1 36 1 0
4 43 8 5 1 37 1 0   4 38 8 8 1 38 1 0
4 4B 8 3 1 39 1 0   4 43 8 5 1 3A 1 0
4 38 8 8 1 3B 1 0   4 4B 8 3 1 3C 1 0
4 54 8 1 1 3D 1 0   4 38 8 8 2 3D 1 0
// Press after the win
1 0 0 8 0 00 0 0
0 0 0 0 0 00 0 0

//--- all.f
+incdir+src
src/tuner_pkg.sv
src/note_detector.sv
src/melody_rom.sv
src/game_controller.sv
src/singing_game_top.sv
test/tb_checker.sv
test/tb_top.sv

//--- test/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuner_consts.svh"

module tb_top;

    localparam int clk_hz        = 44000;
    localparam int stable_cycles = 32;
    localparam int max_period    = 1023;
    localparam int reset_cycles  = 16;
    localparam int rest_len      = 1200;
    localparam int key_len       = 8;
    localparam int row_words     = 8;
    localparam int max_rows      = 128;

    // Row actions in the data file
    localparam int act_end   = 0;
    localparam int act_key   = 1;
    localparam int act_tone  = 2;
    localparam int act_quiet = 3;
    localparam int act_sing  = 4;

    // Square wave at plus and minus full scale
    localparam logic [`MIC_W - 1:0] mic_high = {1'b0, {(`MIC_W - 1){1'b1}}};
    localparam logic [`MIC_W - 1:0] mic_low  = {1'b1, {(`MIC_W - 2){1'b0}}, 1'b1};

    logic                  clk;
    logic                  rst;
    logic                  start_key;
    logic [`MIC_W - 1:0]   mic;
    wire  [`NOTE_W - 1:0]  heard_note;
    wire  [1:0]            game_state;
    wire  [`INDEX_W - 1:0] note_index;
    wire                   hit;
    wire                   miss;

    logic                  check;
    int                    row;
    logic [`NOTE_W - 1:0]  exp_heard;
    logic [1:0]            exp_state;
    logic [`INDEX_W - 1:0] exp_index;
    logic                  exp_hit;
    logic                  exp_miss;
    int                    checks;
    int                    errors;
    int                    row_errors;

    logic [31:0]           words [0:row_words * max_rows - 1];
    int                    cycle_limit;
    int                    cycles;

    singing_game_top #(
        .clk_hz        (clk_hz),
        .stable_cycles (stable_cycles),
        .max_period    (max_period)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .start_key  (start_key),
        .mic        (mic),
        .heard_note (heard_note),
        .game_state (game_state),
        .note_index (note_index),
        .hit        (hit),
        .miss       (miss)
    );

    tb_checker u_checker (
        .clk        (clk),
        .check      (check),
        .row        (row),
        .exp_heard  (exp_heard),
        .exp_state  (exp_state),
        .exp_index  (exp_index),
        .exp_hit    (exp_hit),
        .exp_miss   (exp_miss),
        .heard_note (heard_note),
        .game_state (game_state),
        .note_index (note_index),
        .hit        (hit),
        .miss       (miss),
        .checks     (checks),
        .errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // Cycles a row takes, including its check strobe
    function automatic int row_cycles(input int r);
        int act;
        int half;
        int periods;
        act     = words[r * row_words];
        half    = words[r * row_words + 1];
        periods = words[r * row_words + 2];
        case (act)
            act_key:   return key_len + 1;
            act_tone:  return 2 * half * periods + 1;
            act_quiet: return half + 1;
            act_sing:  return rest_len + 2 * half * periods + 1;
            default:   return 1;
        endcase
    endfunction

    // Called on a falling edge, returns on a falling edge
    task automatic hold_mic(input logic [`MIC_W - 1:0] value, input int len);
        mic = value;
        repeat (len) @(negedge clk);
    endtask

    // Each period is a negative half then a positive half
    task automatic play_tone(input int half, input int periods);
        repeat (periods) begin
            hold_mic(mic_low, half);
            hold_mic(mic_high, half);
        end
    endtask

    task automatic press_key();
        start_key = 1'b1;
        repeat (key_len / 2) @(negedge clk);
        start_key = 1'b0;
        repeat (key_len / 2) @(negedge clk);
    endtask

    task automatic strobe_check(input int r);
        int base;
        base      = r * row_words;
        row       = r;
        exp_heard = words[base + 3][`NOTE_W - 1:0];
        exp_state = words[base + 4][1:0];
        exp_index = words[base + 5][`INDEX_W - 1:0];
        exp_hit   = words[base + 6][0];
        exp_miss  = words[base + 7][0];
        check     = 1'b1;
        @(negedge clk);
        check     = 1'b0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int r;
        int act;
        int total;
        rst        = 1'b1;
        start_key  = 1'b0;
        mic        = '0;
        check      = 1'b0;
        row        = 0;
        exp_heard  = '0;
        exp_state  = '0;
        exp_index  = '0;
        exp_hit    = 1'b0;
        exp_miss   = 1'b0;
        row_errors = 0;
        $readmemh("test/game_input.txt", words);
        if ($isunknown(words[0])) begin
            $display("Could not read stimulus rows from test/game_input.txt");
            $display("Test failed");
            $finish;
        end else begin
            r     = 0;
            total = 0;
            while (r < max_rows && words[r * row_words] != act_end) begin
                total = total + row_cycles(r);
                r++;
            end
            cycle_limit = total + reset_cycles + 2000;

            repeat (reset_cycles) @(negedge clk);
            rst = 1'b0;

            r = 0;
            while (r < max_rows && words[r * row_words] != act_end) begin
                act = words[r * row_words];
                case (act)
                    act_key:   press_key();
                    act_tone:  play_tone(words[r * row_words + 1], words[r * row_words + 2]);
                    act_quiet: hold_mic('0, words[r * row_words + 1]);
                    act_sing: begin
                        hold_mic('0, rest_len);
                        play_tone(words[r * row_words + 1], words[r * row_words + 2]);
                    end
                    default: begin
                        $display("Row %0d has an unknown action code %0d", r, act);
                        row_errors++;
                    end
                endcase
                strobe_check(r);
                r++;
            end

            @(negedge clk);
            $display("Rows: %0d, checks: %0d, value errors: %0d, row errors: %0d",
                     r, checks, errors, row_errors);
            if (errors == 0 && row_errors == 0 && checks == r && r > 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    // Watchdog, armed once the row lengths are known
    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the stimulus rows did not finish", cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuner_consts.svh"

module tb_checker (
    input  wire                  clk,
    input  wire                  check,
    input  wire [31:0]           row,
    input  wire [`NOTE_W - 1:0]  exp_heard,
    input  wire [1:0]            exp_state,
    input  wire [`INDEX_W - 1:0] exp_index,
    input  wire                  exp_hit,
    input  wire                  exp_miss,
    input  wire [`NOTE_W - 1:0]  heard_note,
    input  wire [1:0]            game_state,
    input  wire [`INDEX_W - 1:0] note_index,
    input  wire                  hit,
    input  wire                  miss,
    output int                   checks,
    output int                   errors
);

    initial begin
        checks = 0;
        errors = 0;
    end

    task automatic compare_field(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAILED row %0d: %s expected %h, got %h", row, name, expected, actual);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Compare on each check strobe
    // ----------------------------------------

    // Outputs are registered, so the rising edge sees settled values
    always @(posedge clk) begin
        if (check) begin
            checks++;
            compare_field("heard_note", 8'(exp_heard), 8'(heard_note));
            compare_field("game_state", 8'(exp_state), 8'(game_state));
            compare_field("note_index", 8'(exp_index), 8'(note_index));
            compare_field("hit", 8'(exp_hit), 8'(hit));
            compare_field("miss", 8'(exp_miss), 8'(miss));
        end
    end

endmodule

`default_nettype wire

//--- src/singing_game_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuner_consts.svh"

module singing_game_top #(
    parameter int clk_hz        = 44000,
    parameter int stable_cycles = 32,
    parameter int max_period    = 1023
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start_key,
    input  wire [`MIC_W - 1:0]      mic,
    output tuner_pkg::note_t        heard_note,
    output tuner_pkg::game_state_t  game_state,
    output logic [`INDEX_W - 1:0]   note_index,
    output logic                    hit,
    output logic                    miss
);

    import tuner_pkg::*;

    note_t target_note;

    note_detector #(
        .clk_hz        (clk_hz),
        .stable_cycles (stable_cycles),
        .max_period    (max_period)
    ) u_note_detector (
        .clk        (clk),
        .rst        (rst),
        .mic        (mic),
        .heard_note (heard_note)
    );

    // Combinational lookup of the note to sing next
    melody_rom u_melody_rom (
        .note_index  (note_index),
        .target_note (target_note)
    );

    game_controller u_game_controller (
        .clk         (clk),
        .rst         (rst),
        .start_key   (start_key),
        .heard_note  (heard_note),
        .target_note (target_note),
        .note_index  (note_index),
        .game_state  (game_state),
        .hit         (hit),
        .miss        (miss)
    );

endmodule

`default_nettype wire

//--- src/game_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuner_consts.svh"

module game_controller (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start_key,
    input  wire tuner_pkg::note_t   heard_note,
    input  wire tuner_pkg::note_t   target_note,
    output logic [`INDEX_W - 1:0]   note_index,
    output tuner_pkg::game_state_t  game_state,
    output logic                    hit,
    output logic                    miss
);

    import tuner_pkg::*;

    logic  prev_key;
    logic  key_press;
    note_t prev_heard;
    logic  note_event;
    logic  last_note;

    // ----------------------------------------
    // Key edge and note events
    // ----------------------------------------

    // Registered edge, so a press acts two cycles after it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_key  <= 1'b0;
            key_press <= 1'b0;
        end else begin
            prev_key  <= start_key;
            key_press <= start_key & ~prev_key;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_heard <= NOTE_NONE;
        end else begin
            prev_heard <= heard_note;
        end
    end

    // New stable note, a drop back to silence is not an event
    assign note_event = (heard_note != prev_heard) && (heard_note != NOTE_NONE);
    assign last_note  = (note_index == `INDEX_W'(`MELODY_LEN - 1));

    // ----------------------------------------
    // Game FSM
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state <= IDLE;
            note_index <= '0;
            hit        <= 1'b0;
            miss       <= 1'b0;
        end else begin
            case (game_state)
                IDLE: begin
                    if (key_press) begin
                        game_state <= PLAYING;
                        note_index <= '0;
                    end
                end
                PLAYING: begin
                    if (key_press) begin
                        // Abort
                        game_state <= IDLE;
                        note_index <= '0;
                        hit        <= 1'b0;
                        miss       <= 1'b0;
                    end else if (note_event) begin
                        if (heard_note == target_note) begin
                            hit <= 1'b1;
                            if (last_note) begin
                                game_state <= WIN;
                            end else begin
                                note_index <= note_index + 1'b1;
                            end
                        end else begin
                            hit        <= 1'b0;
                            miss       <= 1'b1;
                            game_state <= FAIL;
                        end
                    end
                end
                WIN, FAIL: begin
                    if (key_press) begin
                        game_state <= IDLE;
                        note_index <= '0;
                        hit        <= 1'b0;
                        miss       <= 1'b0;
                    end
                end
                default: begin
                    game_state <= IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(hit && miss))
        else $error("hit and miss both high");

    // Index never runs past the tune
    assert property (@(posedge clk) disable iff (rst) note_index < `MELODY_LEN)
        else $error("note_index past melody end: %0d", note_index);

endmodule

`default_nettype wire

//--- src/melody_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuner_consts.svh"

module melody_rom (
    input  wire [`INDEX_W - 1:0]    note_index,
    output tuner_pkg::note_t        target_note
);

    import tuner_pkg::*;

    always_comb begin
        case (note_index)
            // Phrase 1
            0:  target_note = NOTE_E;
            1:  target_note = NOTE_G;
            2:  target_note = NOTE_D;
            3:  target_note = NOTE_C;
            4:  target_note = NOTE_D;
            5:  target_note = NOTE_E;
            6:  target_note = NOTE_G;
            7:  target_note = NOTE_D;
            // Phrase 2
            8:  target_note = NOTE_E;
            9:  target_note = NOTE_G;
            10: target_note = NOTE_D;
            11: target_note = NOTE_C;
            12: target_note = NOTE_G;
            13: target_note = NOTE_F;
            14: target_note = NOTE_E;
            15: target_note = NOTE_D;
            // Phrase 1 again
            16: target_note = NOTE_E;
            17: target_note = NOTE_G;
            18: target_note = NOTE_D;
            19: target_note = NOTE_C;
            20: target_note = NOTE_D;
            21: target_note = NOTE_E;
            22: target_note = NOTE_G;
            23: target_note = NOTE_D;
            // Cadence
            24: target_note = NOTE_E;
            25: target_note = NOTE_G;
            26: target_note = NOTE_D;
            27: target_note = NOTE_C;
            28: target_note = NOTE_G;
            // Bridge
            29: target_note = NOTE_G;
            30: target_note = NOTE_F;
            31: target_note = NOTE_E;
            32: target_note = NOTE_F;
            33: target_note = NOTE_E;
            34: target_note = NOTE_C;
            35: target_note = NOTE_F;
            36: target_note = NOTE_E;
            37: target_note = NOTE_D;
            38: target_note = NOTE_E;
            39: target_note = NOTE_D;
            40: target_note = NOTE_A;
            41: target_note = NOTE_G;
            42: target_note = NOTE_F;
            43: target_note = NOTE_E;
            44: target_note = NOTE_F;
            45: target_note = NOTE_E;
            46: target_note = NOTE_C;
            47: target_note = NOTE_F;
            48: target_note = NOTE_C;
            // Return of phrase 1
            49: target_note = NOTE_E;
            50: target_note = NOTE_G;
            51: target_note = NOTE_D;
            52: target_note = NOTE_C;
            53: target_note = NOTE_D;
            54: target_note = NOTE_E;
            55: target_note = NOTE_G;
            56: target_note = NOTE_D;
            // Final cadence
            57: target_note = NOTE_E;
            58: target_note = NOTE_G;
            59: target_note = NOTE_D;
            60: target_note = NOTE_C;
            61: target_note = NOTE_G;
            default: target_note = NOTE_NONE;
        endcase
    end

endmodule

`default_nettype wire

//--- src/note_detector.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuner_consts.svh"

module note_detector #(
    parameter int clk_hz        = 44000,
    parameter int stable_cycles = 32,
    parameter int max_period    = 1023
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`MIC_W - 1:0]      mic,
    output tuner_pkg::note_t        heard_note
);

    import tuner_pkg::*;

    localparam int cnt_w = $clog2(stable_cycles + 1);

    localparam int freq100_table [12] = '{
        `FREQ100_C,
        `FREQ100_CS,
        `FREQ100_D,
        `FREQ100_DS,
        `FREQ100_E,
        `FREQ100_F,
        `FREQ100_FS,
        `FREQ100_G,
        `FREQ100_GS,
        `FREQ100_A,
        `FREQ100_AS,
        `FREQ100_B
    };

    // Window edge in clock cycles, 64-bit so large clocks do not overflow
    function automatic longint window_edge(input int freq100, input int mult, input int tol);
        return (longint'(clk_hz) * tol) / (longint'(freq100) * mult);
    endfunction

    logic                   prev_sign;
    logic                   crossing;
    logic [`PERIOD_W - 1:0] counter;
    logic [`PERIOD_W - 1:0] period;
    note_t                  note_class;
    note_t                  cand_note;
    logic [cnt_w - 1:0]     stable_cnt;

    // ----------------------------------------
    // Zero crossing period
    // ----------------------------------------

    // Sign goes from negative to non-negative
    assign crossing = prev_sign & ~mic[`MIC_W - 1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_sign <= 1'b0;
            counter   <= '0;
            period    <= '0;
        end else begin
            prev_sign <= mic[`MIC_W - 1];
            if (crossing) begin
                period  <= counter;
                counter <= '0;
            end else if (counter == `PERIOD_W'(max_period)) begin
                // Silence, counter parks here until the next crossing
                period <= '0;
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Period to note class
    // ----------------------------------------

    // First matching window wins; a zero period never matches
    always_comb begin : classify
        logic found;
        found      = 1'b0;
        note_class = NOTE_NONE;
        for (int n = 0; n < 12; n++) begin
            for (int m = 1; m <= 4; m = m * 2) begin
                if (!found
                    && period > window_edge(freq100_table[n], m, `TOL_LOW)
                    && period < window_edge(freq100_table[n], m, `TOL_HIGH)) begin
                    note_class = note_t'(n + 1);
                    found      = 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Stability filter
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cand_note  <= NOTE_NONE;
            stable_cnt <= '0;
            heard_note <= NOTE_NONE;
        end else begin
            cand_note <= note_class;
            if (note_class != cand_note) begin
                stable_cnt <= '0;
            end else if (stable_cnt != cnt_w'(stable_cycles)) begin
                stable_cnt <= stable_cnt + 1'b1;
            end else begin
                heard_note <= cand_note;
            end
        end
    end

    // Only legal codes reach the game
    assert property (@(posedge clk) disable iff (rst) heard_note <= NOTE_B)
        else $error("heard_note out of range: %0d", heard_note);

endmodule

`default_nettype wire

//--- src/tuner_pkg.sv
`default_nettype none

`include "tuner_consts.svh"

package tuner_pkg;

    // Note codes in ascending pitch, zero means silence
    typedef enum logic [`NOTE_W - 1:0] {
        NOTE_NONE = 0,
        NOTE_C,
        NOTE_CS,
        NOTE_D,
        NOTE_DS,
        NOTE_E,
        NOTE_F,
        NOTE_FS,
        NOTE_G,
        NOTE_GS,
        NOTE_A,
        NOTE_AS,
        NOTE_B
    } note_t;

    typedef enum logic [1:0] {
        IDLE,
        PLAYING,
        WIN,
        FAIL
    } game_state_t;

endpackage

`default_nettype wire

//--- src/tuner_consts.svh
`ifndef TUNER_CONSTS_SVH
`define TUNER_CONSTS_SVH

// ----------------------------------------
// Widths
// ----------------------------------------

`define NOTE_W      4
`define PERIOD_W    20
`define MIC_W       24
`define INDEX_W     6

// Tune length in notes
`define MELODY_LEN  62

// ----------------------------------------
// Base octave, hundredths of a hertz
// ----------------------------------------

`define FREQ100_C   26163
`define FREQ100_CS  27718
`define FREQ100_D   29366
`define FREQ100_DS  31113
`define FREQ100_E   32963
`define FREQ100_F   34923
`define FREQ100_FS  36999
`define FREQ100_G   39200
`define FREQ100_GS  41530
`define FREQ100_A   44000
`define FREQ100_AS  46616
`define FREQ100_B   49388

// Match window, percent of the nominal period
`define TOL_LOW     97
`define TOL_HIGH    103

`endif
